// File: source/dbg_pkg.sv
package dbg_pkg;

    localparam int NB_BYTE        = 8;
    localparam int NB_WORD        = 32;
    localparam int BYTES_PER_WORD = NB_WORD / NB_BYTE;

    // Single-byte commands received over the UART
    typedef enum logic [NB_BYTE-1:0] {
        CMD_LOAD      = 8'd1,
        CMD_START     = 8'd2,
        CMD_STEP_MODE = 8'd3,
        CMD_SEND_BR   = 8'd4,
        CMD_SEND_MEM  = 8'd5,
        CMD_SEND_PC   = 8'd6,
        CMD_STEP      = 8'd7,
        CMD_CONTINUE  = 8'd8
    } cmd_e;

    typedef enum logic [3:0] {
        IDLE,
        LOAD,
        READY,
        RUN,
        STEP,
        SEND_PC,
        SEND_MEM,
        SEND_BR
    } state_e;

    // Which word goes out on the UART
    typedef enum logic [1:0] {
        SRC_PC,
        SRC_DM,
        SRC_RB
    } src_e;

    typedef struct packed {
        logic               valid;  // One-cycle pulse per byte
        logic [NB_BYTE-1:0] data;
    } uart_rx_t;

    typedef struct packed {
        logic               start;  // Held until done
        logic [NB_BYTE-1:0] data;
    } uart_tx_t;

    // Processor block enables
    typedef struct packed {
        logic im_en;
        logic rb_en;
        logic dm_en;
        logic cu_en;
        logic pc_en;
    } run_ctrl_t;

endpackage

// File: source/dbg_control.sv
`timescale 1ns/1ns

module dbg_control (
    input  logic               i_clock,
    input  logic               i_reset,
    input  dbg_pkg::uart_rx_t  i_rx,
    input  logic               i_hlt,
    input  logic               i_load_last,
    input  logic               i_word_done,
    input  logic               i_dump_last,
    output logic               o_load_en,
    output logic               o_send_en,
    output dbg_pkg::src_e      o_src,
    output dbg_pkg::run_ctrl_t o_run,
    output logic               o_step_flag,
    output logic               o_step
);

    dbg_pkg::state_e state;
    dbg_pkg::state_e next_state;
    dbg_pkg::cmd_e   cmd;
    logic            step_flag;
    logic            step_flag_next;
    logic            step;
    logic            run_on;
    logic            dump_end;

    assign cmd      = dbg_pkg::cmd_e'(i_rx.data);
    assign dump_end = i_word_done && i_dump_last;  // Final word of current source

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= dbg_pkg::IDLE;
            step_flag <= 1'b0;
            step      <= 1'b0;
        end else begin
            state     <= next_state;
            step_flag <= step_flag_next;
            // Pulse on the edge that starts the step dump
            step      <= (state == dbg_pkg::STEP) && (next_state == dbg_pkg::SEND_PC);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dbg_pkg::IDLE: begin
                if (i_rx.valid) begin
                    case (cmd)
                        dbg_pkg::CMD_LOAD:     next_state = dbg_pkg::LOAD;
                        dbg_pkg::CMD_SEND_PC:  next_state = dbg_pkg::SEND_PC;
                        dbg_pkg::CMD_SEND_MEM: next_state = dbg_pkg::SEND_MEM;
                        dbg_pkg::CMD_SEND_BR:  next_state = dbg_pkg::SEND_BR;
                        default:               next_state = dbg_pkg::IDLE;
                    endcase
                end
            end
            dbg_pkg::LOAD: begin
                if (i_load_last) begin
                    next_state = dbg_pkg::READY;
                end
            end
            dbg_pkg::READY: begin
                if (i_rx.valid) begin
                    case (cmd)
                        dbg_pkg::CMD_START:     next_state = dbg_pkg::RUN;
                        dbg_pkg::CMD_STEP_MODE: next_state = dbg_pkg::STEP;
                        default:                next_state = dbg_pkg::READY;
                    endcase
                end
            end
            dbg_pkg::RUN: begin
                if (i_hlt) begin
                    next_state = dbg_pkg::IDLE;
                end
            end
            dbg_pkg::STEP: begin
                // Halt wins over a command in the same cycle
                if (i_hlt) begin
                    next_state = dbg_pkg::IDLE;
                end else if (i_rx.valid) begin
                    case (cmd)
                        dbg_pkg::CMD_STEP:     next_state = dbg_pkg::SEND_PC;
                        dbg_pkg::CMD_CONTINUE: next_state = dbg_pkg::RUN;
                        default:               next_state = dbg_pkg::STEP;
                    endcase
                end
            end
            dbg_pkg::SEND_PC: begin
                if (dump_end) begin
                    next_state = step_flag ? dbg_pkg::SEND_MEM : dbg_pkg::IDLE;
                end
            end
            dbg_pkg::SEND_MEM: begin
                if (dump_end) begin
                    next_state = step_flag ? dbg_pkg::SEND_BR : dbg_pkg::IDLE;
                end
            end
            dbg_pkg::SEND_BR: begin
                if (dump_end) begin
                    next_state = step_flag ? dbg_pkg::STEP : dbg_pkg::IDLE;
                end
            end
            default: next_state = dbg_pkg::IDLE;
        endcase
    end

    // Flag survives the dump chain that follows a step
    always_comb begin
        case (next_state)
            dbg_pkg::STEP:     step_flag_next = 1'b1;
            dbg_pkg::SEND_PC,
            dbg_pkg::SEND_MEM,
            dbg_pkg::SEND_BR:  step_flag_next = step_flag;
            default:           step_flag_next = 1'b0;
        endcase
    end

    always_comb begin
        case (state)
            dbg_pkg::SEND_MEM: o_src = dbg_pkg::SRC_DM;
            dbg_pkg::SEND_BR:  o_src = dbg_pkg::SRC_RB;
            default:           o_src = dbg_pkg::SRC_PC;
        endcase
    end

    assign run_on    = (state == dbg_pkg::RUN) || (state == dbg_pkg::STEP);
    assign o_load_en = (state == dbg_pkg::LOAD);
    assign o_send_en = (state == dbg_pkg::SEND_PC) || (state == dbg_pkg::SEND_MEM)
                    || (state == dbg_pkg::SEND_BR);

    assign o_run = '{im_en: run_on, rb_en: run_on, dm_en: run_on, cu_en: run_on, pc_en: run_on};

    assign o_step_flag = step_flag;
    assign o_step      = step;

endmodule

// File: source/dbg_loader.sv
`timescale 1ns/1ns

module dbg_loader #(
    parameter  int IM_DEPTH   = 256,
    localparam int NB_IM_ADDR = $clog2(IM_DEPTH)
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_load_en,
    input  dbg_pkg::uart_rx_t           i_rx,
    output logic                        o_im_we,
    output logic [NB_IM_ADDR-1:0]       o_im_addr,
    output logic [dbg_pkg::NB_BYTE-1:0] o_im_data,
    output logic                        o_load_last
);

    logic [NB_IM_ADDR-1:0] addr_cnt;  // Address of the next byte
    logic                  accept;
    logic                  at_last;

    assign accept  = i_load_en && i_rx.valid;
    assign at_last = (addr_cnt == NB_IM_ADDR'(IM_DEPTH - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            addr_cnt    <= '0;
            o_im_we     <= 1'b0;
            o_load_last <= 1'b0;
        end else begin
            o_im_we     <= accept;
            o_load_last <= accept && at_last;  // Marks the final write
            if (accept) begin
                addr_cnt <= at_last ? '0 : addr_cnt + 1'b1;
            end
        end
    end

    // Write port follows the accepted byte by one cycle
    always_ff @(posedge i_clock) begin
        if (accept) begin
            o_im_addr <= addr_cnt;
            o_im_data <= i_rx.data;
        end
    end

endmodule

// File: source/dbg_word_sender.sv
`timescale 1ns/1ns

module dbg_word_sender (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_send_en,
    input  dbg_pkg::src_e               i_src,
    input  logic [dbg_pkg::NB_WORD-1:0] i_pc_value,
    input  logic [dbg_pkg::NB_WORD-1:0] i_dm_data,
    input  logic [dbg_pkg::NB_WORD-1:0] i_rb_data,
    input  logic                        i_tx_done,
    output dbg_pkg::uart_tx_t           o_tx,
    output logic                        o_word_done
);

    localparam int NB_IDX = $clog2(dbg_pkg::BYTES_PER_WORD);

    logic [dbg_pkg::NB_WORD-1:0] word;
    logic [dbg_pkg::NB_BYTE-1:0] next_byte;
    logic [dbg_pkg::NB_BYTE-1:0] tx_data;
    logic [NB_IDX-1:0]           byte_idx;  // 0 is the MSB
    logic                        tx_start;
    logic                        consumed;
    logic                        last_byte;
    logic                        offer;

    always_comb begin
        case (i_src)
            dbg_pkg::SRC_DM: word = i_dm_data;
            dbg_pkg::SRC_RB: word = i_rb_data;
            default:         word = i_pc_value;
        endcase
    end

    assign next_byte = word[(dbg_pkg::BYTES_PER_WORD - 1 - int'(byte_idx)) * dbg_pkg::NB_BYTE
                            +: dbg_pkg::NB_BYTE];

    assign consumed  = tx_start && i_tx_done;
    assign last_byte = (byte_idx == NB_IDX'(dbg_pkg::BYTES_PER_WORD - 1));
    assign offer     = !tx_start && i_send_en;  // Low start for a cycle gives the gap

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            tx_start <= 1'b0;
            byte_idx <= '0;
        end else if (consumed) begin
            tx_start <= 1'b0;
            byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
        end else if (offer) begin
            tx_start <= 1'b1;
        end
    end

    // Byte held stable for the whole handshake
    always_ff @(posedge i_clock) begin
        if (offer) begin
            tx_data <= next_byte;
        end
    end

    assign o_tx        = '{start: tx_start, data: tx_data};
    assign o_word_done = consumed && last_byte;

endmodule

// File: source/dbg_dump_counter.sv
`timescale 1ns/1ns

module dbg_dump_counter #(
    parameter  int DM_DEPTH   = 32,
    parameter  int RB_DEPTH   = 32,
    localparam int NB_DM_ADDR = $clog2(DM_DEPTH),
    localparam int NB_RB_ADDR = $clog2(RB_DEPTH)
) (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_send_en,
    input  dbg_pkg::src_e         i_src,
    input  logic                  i_word_done,
    output logic [NB_DM_ADDR-1:0] o_dm_addr,
    output logic [NB_RB_ADDR-1:0] o_rb_addr,
    output logic                  o_dm_rd_en,
    output logic                  o_rb_rd_en,
    output logic                  o_dump_last
);

    localparam int NB_CNT = (NB_DM_ADDR > NB_RB_ADDR) ? NB_DM_ADDR : NB_RB_ADDR;

    logic [NB_CNT-1:0] word_cnt;
    logic [NB_CNT-1:0] last_idx;

    // PC dump is a single word
    always_comb begin
        case (i_src)
            dbg_pkg::SRC_DM: last_idx = NB_CNT'(DM_DEPTH - 1);
            dbg_pkg::SRC_RB: last_idx = NB_CNT'(RB_DEPTH - 1);
            default:         last_idx = '0;
        endcase
    end

    assign o_dump_last = i_send_en && (word_cnt == last_idx);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            word_cnt <= '0;
        end else if (i_word_done) begin
            word_cnt <= o_dump_last ? '0 : word_cnt + 1'b1;  // Clears at dump end
        end
    end

    assign o_dm_addr  = word_cnt[NB_DM_ADDR-1:0];
    assign o_rb_addr  = word_cnt[NB_RB_ADDR-1:0];
    assign o_dm_rd_en = i_send_en && (i_src == dbg_pkg::SRC_DM);
    assign o_rb_rd_en = i_send_en && (i_src == dbg_pkg::SRC_RB);

endmodule

// File: source/debug_unit.sv
`timescale 1ns/1ns

module debug_unit #(
    parameter  int IM_DEPTH   = 256,
    parameter  int DM_DEPTH   = 32,
    parameter  int RB_DEPTH   = 32,
    localparam int NB_IM_ADDR = $clog2(IM_DEPTH),
    localparam int NB_DM_ADDR = $clog2(DM_DEPTH),
    localparam int NB_RB_ADDR = $clog2(RB_DEPTH)
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  dbg_pkg::uart_rx_t           i_rx,
    input  logic                        i_hlt,
    input  logic                        i_tx_done,
    input  logic [dbg_pkg::NB_WORD-1:0] i_pc_value,
    input  logic [dbg_pkg::NB_WORD-1:0] i_dm_data,
    input  logic [dbg_pkg::NB_WORD-1:0] i_rb_data,
    output dbg_pkg::uart_tx_t           o_tx,
    output logic                        o_im_we,
    output logic [NB_IM_ADDR-1:0]       o_im_addr,
    output logic [dbg_pkg::NB_BYTE-1:0] o_im_data,
    output logic [NB_DM_ADDR-1:0]       o_dm_addr,
    output logic                        o_dm_rd_en,
    output logic [NB_RB_ADDR-1:0]       o_rb_addr,
    output logic                        o_rb_rd_en,
    output dbg_pkg::run_ctrl_t          o_run,
    output logic                        o_step_flag,
    output logic                        o_step
);

    logic          load_en;
    logic          load_last;
    logic          send_en;
    logic          word_done;
    logic          dump_last;
    dbg_pkg::src_e src;

    dbg_control u_control (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_rx        (i_rx),
        .i_hlt       (i_hlt),
        .i_load_last (load_last),
        .i_word_done (word_done),
        .i_dump_last (dump_last),
        .o_load_en   (load_en),
        .o_send_en   (send_en),
        .o_src       (src),
        .o_run       (o_run),
        .o_step_flag (o_step_flag),
        .o_step      (o_step)
    );

    dbg_loader #(.IM_DEPTH(IM_DEPTH)) u_loader (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_load_en   (load_en),
        .i_rx        (i_rx),
        .o_im_we     (o_im_we),
        .o_im_addr   (o_im_addr),
        .o_im_data   (o_im_data),
        .o_load_last (load_last)
    );

    // Byte serializer for PC, DM and RB words
    dbg_word_sender u_sender (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_send_en   (send_en),
        .i_src       (src),
        .i_pc_value  (i_pc_value),
        .i_dm_data   (i_dm_data),
        .i_rb_data   (i_rb_data),
        .i_tx_done   (i_tx_done),
        .o_tx        (o_tx),
        .o_word_done (word_done)
    );

    dbg_dump_counter #(
        .DM_DEPTH (DM_DEPTH),
        .RB_DEPTH (RB_DEPTH)
    ) u_dump_counter (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_send_en   (send_en),
        .i_src       (src),
        .i_word_done (word_done),
        .o_dm_addr   (o_dm_addr),
        .o_rb_addr   (o_rb_addr),
        .o_dm_rd_en  (o_dm_rd_en),
        .o_rb_rd_en  (o_rb_rd_en),
        .o_dump_last (dump_last)
    );

endmodule

// File: tb/debug_unit_sva.sv
`timescale 1ns/1ns

module debug_unit_sva (
    input logic               i_clock,
    input logic               i_reset,
    input logic               i_tx_done,
    input dbg_pkg::uart_tx_t  o_tx,
    input dbg_pkg::run_ctrl_t o_run,
    input logic               o_step_flag,
    input logic               o_step,
    input logic               o_im_we,
    input logic               o_dm_rd_en,
    input logic               o_rb_rd_en
);

    logic [4:0] run_bits;
    int         fail_count = 0;  // Read by the testbench top

    assign run_bits = o_run;

    // Byte held until the UART takes it
    a_tx_hold: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_tx.start && !i_tx_done) |=> (o_tx.start && $stable(o_tx.data)))
        else begin
            fail_count++;
            $error("tx byte dropped or changed before done");
        end

    a_step_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        o_step |=> !o_step)
        else begin
            fail_count++;
            $error("step pulse longer than one cycle");
        end

    // Enables move together and never during a dump
    a_run_equal: assert property (@(posedge i_clock) disable iff (i_reset)
        (|run_bits) |-> (&run_bits && !o_tx.start && !o_dm_rd_en && !o_rb_rd_en))
        else begin
            fail_count++;
            $error("run enables disagree or overlap a dump");
        end

    a_reset_quiet: assert property (@(posedge i_clock)
        i_reset |=> (run_bits == 5'b00000 && !o_step_flag && !o_step && !o_im_we
                     && !o_dm_rd_en && !o_rb_rd_en && !o_tx.start))
        else begin
            fail_count++;
            $error("control output high right after reset");
        end

endmodule

bind debug_unit debug_unit_sva u_sva (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_tx_done   (i_tx_done),
    .o_tx        (o_tx),
    .o_run       (o_run),
    .o_step_flag (o_step_flag),
    .o_step      (o_step),
    .o_im_we     (o_im_we),
    .o_dm_rd_en  (o_dm_rd_en),
    .o_rb_rd_en  (o_rb_rd_en)
);

// File: tb/dbg_checker.sv
`timescale 1ns/1ns

module dbg_checker #(
    parameter  int IM_DEPTH   = 256,
    localparam int NB_IM_ADDR = $clog2(IM_DEPTH)
) (
    input logic                  i_clock,
    input logic                  i_reset,
    input dbg_pkg::uart_tx_t     i_tx,
    input logic                  i_tx_done,
    input logic                  i_im_we,
    input logic [NB_IM_ADDR-1:0] i_im_addr,
    input logic [7:0]            i_im_data,
    input dbg_pkg::run_ctrl_t    i_run,
    input logic                  i_step_flag,
    input logic                  i_step
);

    logic [7:0]            exp_tx[$];
    logic [NB_IM_ADDR+7:0] exp_im[$];  // Address above data
    logic [7:0]            exp_byte;
    logic [NB_IM_ADDR+7:0] exp_wr;
    int    tx_pending = 0;
    int    im_pending = 0;
    int    step_count = 0;
    int    checks = 0;
    int    errors = 0;
    int    tests = 0;
    int    failed_tests = 0;
    int    errors_at_start = 0;
    string test_name;

    task automatic expect_tx(input logic [7:0] b);
        exp_tx.push_back(b);
        tx_pending++;
    endtask

    task automatic expect_im(input logic [NB_IM_ADDR-1:0] addr, input logic [7:0] data);
        exp_im.push_back({addr, data});
        im_pending++;
    endtask

    always @(posedge i_clock) begin
        if (!i_reset) begin
            if (i_step) step_count++;
            if (i_tx.start && i_tx_done) begin  // Byte consumed this cycle
                if (exp_tx.size() == 0) begin
                    errors++;
                    $display("ERROR %0t: tx byte %02h sent but none expected", $time, i_tx.data);
                end else begin
                    exp_byte = exp_tx.pop_front();
                    tx_pending--;
                    checks++;
                    if (i_tx.data !== exp_byte) begin
                        errors++;
                        $display("ERROR %0t: tx byte %02h, expected %02h",
                                 $time, i_tx.data, exp_byte);
                    end
                end
            end
            if (i_im_we) begin
                if (exp_im.size() == 0) begin
                    errors++;
                    $display("ERROR %0t: IM write at %0d but none expected", $time, i_im_addr);
                end else begin
                    exp_wr = exp_im.pop_front();
                    im_pending--;
                    checks++;
                    if ({i_im_addr, i_im_data} !== exp_wr) begin
                        errors++;
                        $display("ERROR %0t: IM write %0d <= %02h, expected %0d <= %02h", $time,
                                 i_im_addr, i_im_data, exp_wr[NB_IM_ADDR+7:8], exp_wr[7:0]);
                    end
                end
            end
        end
    end

    // Step pulse, IM write and tx start are expected low at every probe
    task automatic check_ctrl(input logic exp_run, input logic exp_flag);
        logic [4:0] run_bits;
        string      seen;
        run_bits = i_run;
        checks++;
        if (run_bits !== {5{exp_run}} || i_step_flag !== exp_flag || i_step !== 1'b0
            || i_im_we !== 1'b0 || i_tx.start !== 1'b0) begin
            errors++;
            seen = $sformatf("run %05b flag %0b step %0b im_we %0b start %0b",
                             run_bits, i_step_flag, i_step, i_im_we, i_tx.start);
            $display("ERROR %0t: %s, expected run %0b flag %0b",
                     $time, seen, exp_run, exp_flag);
        end
    endtask

    task automatic check_steps(input int exp_count);
        checks++;
        if (step_count != exp_count) begin
            errors++;
            $display("ERROR %0t: %0d step pulses, expected %0d", $time, step_count, exp_count);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        int n;
        tests++;
        if (exp_tx.size() != 0 || exp_im.size() != 0) begin
            errors++;
            $display("Test %s ended with %0d tx bytes and %0d IM writes never seen",
                     test_name, exp_tx.size(), exp_im.size());
        end
        n = errors - errors_at_start;
        if (n == 0) begin
            $display("test %0d %s: PASS", tests, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAIL with %0d errors", tests, test_name, n);
        end
    endtask

    task automatic report_counts(input int assert_fails);
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests, failed_tests, checks, errors, assert_fails);
    endtask

endmodule

// File: tb/tb_debug_unit.sv
`timescale 1ns/1ns

module tb_debug_unit;

    localparam int IM_DEPTH     = 16;
    localparam int DM_DEPTH     = 8;
    localparam int RB_DEPTH     = 8;
    localparam int NB_IM_ADDR   = $clog2(IM_DEPTH);
    localparam int NB_DM_ADDR   = $clog2(DM_DEPTH);
    localparam int NB_RB_ADDR   = $clog2(RB_DEPTH);
    localparam int NB_WORD      = dbg_pkg::NB_WORD;
    localparam int MAX_TX_DELAY = 5;
    localparam int RX_GAP       = 2;  // Idle cycles after each received byte
    localparam int N_STEPS      = 2;
    localparam int DUMP_BYTES   = 4 * (1 + DM_DEPTH + RB_DEPTH);
    localparam int TX_BYTES     = DUMP_BYTES + 4 + N_STEPS * DUMP_BYTES;
    localparam int RX_BYTES     = 2 * (IM_DEPTH + 1) + 12;
    localparam int LIMIT_CYCLES = TX_BYTES * (MAX_TX_DELAY + 3) + RX_BYTES * (RX_GAP + 1) + 400;

    logic                  clock = 1'b0;
    logic                  reset;
    dbg_pkg::uart_rx_t     rx;
    dbg_pkg::uart_tx_t     tx;
    logic                  hlt;
    logic                  tx_done = 1'b0;
    int                    tx_wait = 0;
    logic [NB_WORD-1:0]    pc_value = 32'h0000_0100;
    logic [NB_WORD-1:0]    dm_data;
    logic [NB_WORD-1:0]    rb_data;
    logic                  im_we;
    logic [NB_IM_ADDR-1:0] im_addr;
    logic [7:0]            im_data;
    logic [NB_DM_ADDR-1:0] dm_addr;
    logic [NB_RB_ADDR-1:0] rb_addr;
    logic                  dm_rd_en;
    logic                  rb_rd_en;
    dbg_pkg::run_ctrl_t    run;
    logic                  step_flag;
    logic                  step;

    always #2 clock = ~clock;

    // Memory contents as functions of the address
    function automatic logic [NB_WORD-1:0] dm_word(input int addr);
        return {8'hD0, 8'(addr), 8'(addr) ^ 8'h5A, 8'(addr * 3 + 1)};
    endfunction

    function automatic logic [NB_WORD-1:0] rb_word(input int addr);
        return {8'hB0, 8'(addr * 5), 8'(addr) ^ 8'hC3, 8'(addr)};
    endfunction

    // Byte idx of a word on the wire, 0 is the MSB
    function automatic logic [7:0] byte_of(input logic [NB_WORD-1:0] word, input int idx);
        return word[NB_WORD - 1 - 8 * idx -: 8];
    endfunction

    assign dm_data = dm_rd_en ? dm_word(int'(dm_addr)) : '0;
    assign rb_data = rb_rd_en ? rb_word(int'(rb_addr)) : '0;

    // UART transmitter takes each byte after 1 to MAX_TX_DELAY cycles
    always @(negedge clock) begin
        if (reset) begin
            tx_done <= 1'b0;
            tx_wait <= 0;
        end else if (tx_done) begin
            tx_done <= 1'b0;
        end else if (tx.start) begin
            if (tx_wait == 0) begin
                tx_wait <= int'($urandom_range(MAX_TX_DELAY, 1));
            end else if (tx_wait == 1) begin
                tx_done <= 1'b1;
                tx_wait <= 0;
            end else begin
                tx_wait <= tx_wait - 1;
            end
        end
    end

    always @(negedge clock) begin
        if (step) pc_value <= pc_value + 32'd4;  // One instruction per step
    end

    debug_unit #(
        .IM_DEPTH (IM_DEPTH),
        .DM_DEPTH (DM_DEPTH),
        .RB_DEPTH (RB_DEPTH)
    ) u_dut (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_rx        (rx),
        .i_hlt       (hlt),
        .i_tx_done   (tx_done),
        .i_pc_value  (pc_value),
        .i_dm_data   (dm_data),
        .i_rb_data   (rb_data),
        .o_tx        (tx),
        .o_im_we     (im_we),
        .o_im_addr   (im_addr),
        .o_im_data   (im_data),
        .o_dm_addr   (dm_addr),
        .o_dm_rd_en  (dm_rd_en),
        .o_rb_addr   (rb_addr),
        .o_rb_rd_en  (rb_rd_en),
        .o_run       (run),
        .o_step_flag (step_flag),
        .o_step      (step)
    );

    dbg_checker #(.IM_DEPTH(IM_DEPTH)) u_chk (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_tx        (tx),
        .i_tx_done   (tx_done),
        .i_im_we     (im_we),
        .i_im_addr   (im_addr),
        .i_im_data   (im_data),
        .i_run       (run),
        .i_step_flag (step_flag),
        .i_step      (step)
    );

    task automatic send_byte(input logic [7:0] b);
        rx = '{valid: 1'b1, data: b};
        @(negedge clock);
        rx.valid = 1'b0;
        repeat (RX_GAP) @(negedge clock);
    endtask

    task automatic expect_word(input logic [NB_WORD-1:0] word);
        for (int i = 0; i < 4; i++) u_chk.expect_tx(byte_of(word, i));
    endtask

    task automatic expect_dm();
        for (int a = 0; a < DM_DEPTH; a++) expect_word(dm_word(a));
    endtask

    task automatic expect_rb();
        for (int a = 0; a < RB_DEPTH; a++) expect_word(rb_word(a));
    endtask

    task automatic wait_drained();
        while (u_chk.tx_pending != 0 || u_chk.im_pending != 0) @(negedge clock);
        repeat (3) @(negedge clock);  // Let the FSM settle
    endtask

    task automatic load_program();
        logic [7:0] b;
        send_byte(dbg_pkg::CMD_LOAD);
        for (int i = 0; i < IM_DEPTH; i++) begin
            b = 8'($urandom);
            u_chk.expect_im(NB_IM_ADDR'(i), b);
            send_byte(b);
        end
        wait_drained();
    endtask

    task automatic pulse_halt();
        hlt = 1'b1;
        @(negedge clock);
        hlt = 1'b0;
        repeat (2) @(negedge clock);
    endtask

    initial begin
        void'($urandom(40));
        reset = 1'b1;
        rx    = '0;
        hlt   = 1'b0;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        u_chk.begin_test("reset and start in idle");
        u_chk.check_ctrl(1'b0, 1'b0);
        send_byte(dbg_pkg::CMD_START);  // Ignored outside READY
        repeat (3) @(negedge clock);
        u_chk.check_ctrl(1'b0, 1'b0);
        u_chk.end_test();

        u_chk.begin_test("program load and start");
        load_program();
        send_byte(dbg_pkg::CMD_START);
        u_chk.check_ctrl(1'b1, 1'b0);
        u_chk.end_test();

        u_chk.begin_test("halt from run");
        pulse_halt();
        u_chk.check_ctrl(1'b0, 1'b0);
        expect_word(pc_value);
        send_byte(dbg_pkg::CMD_SEND_PC);
        wait_drained();
        u_chk.end_test();

        u_chk.begin_test("dumps from idle");
        expect_word(pc_value);
        send_byte(dbg_pkg::CMD_SEND_PC);
        wait_drained();
        expect_dm();
        send_byte(dbg_pkg::CMD_SEND_MEM);
        wait_drained();
        expect_rb();
        send_byte(dbg_pkg::CMD_SEND_BR);
        wait_drained();
        u_chk.end_test();

        u_chk.begin_test("step mode");
        load_program();
        send_byte(dbg_pkg::CMD_STEP_MODE);
        u_chk.check_ctrl(1'b1, 1'b1);
        for (int s = 0; s < N_STEPS; s++) begin
            expect_word(pc_value + 32'd4);  // PC after the step
            expect_dm();
            expect_rb();
            send_byte(dbg_pkg::CMD_STEP);
            wait_drained();
            u_chk.check_ctrl(1'b1, 1'b1);
            u_chk.check_steps(s + 1);
        end
        send_byte(dbg_pkg::CMD_CONTINUE);
        u_chk.check_ctrl(1'b1, 1'b0);
        pulse_halt();
        u_chk.end_test();

        u_chk.report_counts(u_dut.u_sva.fail_count);
        if (u_chk.errors == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Bound from byte counts and the slowest UART answer
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clock);
        $display("Timeout: run still busy after %0d cycles", LIMIT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: list.f
source/dbg_pkg.sv
source/dbg_control.sv
source/dbg_loader.sv
source/dbg_word_sender.sv
source/dbg_dump_counter.sv
source/debug_unit.sv
tb/debug_unit_sva.sv
tb/dbg_checker.sv
tb/tb_debug_unit.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_debug_unit
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
